// File: verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Memory word geometry
    localparam int data_width = 64;
    localparam int byte_len = 8;
    localparam int mask_width = data_width / byte_len;
    localparam int mem_depth = 64;
    localparam int addr_width = $clog2(mem_depth);

    // Entries in each request and response queue
    localparam int queue_depth = 4;

    typedef logic client_id_t;

    localparam client_id_t client_a = 1'b0;
    localparam client_id_t client_b = 1'b1;

    typedef enum logic
    {
        op_read = 1'b0,
        op_write = 1'b1
    } mem_opcode_t;

    // The arbiter overwrites client with the winning port
    typedef struct packed
    {
        client_id_t client;
        mem_opcode_t opcode;
        logic [addr_width - 1 : 0] addr;
        logic [mask_width - 1 : 0] write_mask;
        logic [data_width - 1 : 0] write_data;
    } mem_request_t;

    // Write responses return zero in read_data
    typedef struct packed
    {
        client_id_t client;
        mem_opcode_t opcode;
        logic [data_width - 1 : 0] read_data;
    } mem_response_t;

    typedef enum logic [1:0]
    {
        st_idle = 2'd0,
        st_access = 2'd1,
        st_respond = 2'd2
    } backend_state_t;

endpackage

`default_nettype wire

// File: verilog/dual_port_blockram.sv
`default_nettype none

module dual_port_blockram
#(
    parameter int entry_width = 64,
    parameter int num_entries = 64
)
(
    input logic clk_in,
    input logic reset_in,

    input logic [(entry_width + mem_pkg::byte_len - 1) / mem_pkg::byte_len - 1 : 0]
        port_a_write_mask,
    input logic [$clog2(num_entries) - 1 : 0] port_a_addr,
    input logic [entry_width - 1 : 0] port_a_write_data,

    input logic [$clog2(num_entries) - 1 : 0] port_b_addr,
    output logic [entry_width - 1 : 0] port_b_read_data
);

    import mem_pkg::*;

    logic [entry_width - 1 : 0] mem [num_entries];

    // Each data bit follows the mask bit of the byte lane it sits in
    // A narrow last lane (entry width not a byte multiple) is handled the same way
    always_ff @(posedge clk_in)
    begin
        for (int i = 0; i < entry_width; i++)
        begin
            if (port_a_write_mask[i / byte_len])
            begin
                mem[port_a_addr][i] <= port_a_write_data[i];
            end
        end
    end

    // Registered read, so data shows up one cycle after the address
    // A same-edge write to the same word is not forwarded
    always_ff @(posedge clk_in, posedge reset_in)
    begin
        if (reset_in)
        begin
            port_b_read_data <= '0;
        end
        else
        begin
            port_b_read_data <= mem[port_b_addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/fifo_queue.sv
`default_nettype none

module fifo_queue
#(
    parameter type entry_t = mem_pkg::mem_request_t,
    parameter int depth = mem_pkg::queue_depth,
    parameter storage_type = "FlipFlop"
)
(
    input logic clk_in,
    input logic reset_in,

    output logic is_empty,
    output logic is_full,

    input entry_t request_in,
    input logic request_valid_in,
    output logic issue_ack_out,

    output entry_t request_out,
    output logic request_valid_out,
    input logic issue_ack_in
);

    import mem_pkg::*;

    typedef logic [$clog2(depth) - 1 : 0] ptr_t;

    logic [depth - 1 : 0] entry_valid;
    ptr_t write_ptr;
    ptr_t read_ptr;

    logic push;
    logic pop;

    // Head entry as seen by the output register, per storage mode
    entry_t head_data;
    logic head_ready;

    assign is_full = &entry_valid;
    assign is_empty = ~|entry_valid;

    assign pop = issue_ack_in & request_valid_out & entry_valid[read_ptr];

    // When full the write pointer equals the read pointer, so a pop frees exactly that slot
    assign push = request_valid_in & ~issue_ack_out & (~is_full | pop);

    always_ff @(posedge clk_in, posedge reset_in)
    begin
        if (reset_in)
        begin
            entry_valid <= '0;
            write_ptr <= '0;
            read_ptr <= '0;
            issue_ack_out <= 1'b0;
            request_valid_out <= 1'b0;
        end
        else
        begin
            issue_ack_out <= push;

            if (pop)
            begin
                entry_valid[read_ptr] <= 1'b0;
                read_ptr <= (read_ptr == ptr_t'(depth - 1)) ? '0 : read_ptr + 1'b1;
            end

            // Set after the clear so a full-queue push into the popped slot wins
            if (push)
            begin
                entry_valid[write_ptr] <= 1'b1;
                write_ptr <= (write_ptr == ptr_t'(depth - 1)) ? '0 : write_ptr + 1'b1;
            end

            // Valid drops for at least one cycle after every pop
            request_valid_out <= ~pop & head_ready;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (head_ready)
        begin
            request_out <= head_data;
        end
    end

    generate
        if (storage_type == "FlipFlop")
        begin : gen_flop_storage
            entry_t storage [depth];

            always_ff @(posedge clk_in)
            begin
                if (push)
                begin
                    storage[write_ptr] <= request_in;
                end
            end

            assign head_data = storage[read_ptr];
            assign head_ready = entry_valid[read_ptr];
        end
        else
        begin : gen_ram_storage
            logic [$bits(entry_t) - 1 : 0] ram_read_data;
            logic [($bits(entry_t) + byte_len - 1) / byte_len - 1 : 0] ram_write_mask;
            logic ram_head_valid;

            assign ram_write_mask = {(($bits(entry_t) + byte_len - 1) / byte_len){push}};

            // Tracks whether the word now leaving the RAM read register is a valid head
            always_ff @(posedge clk_in, posedge reset_in)
            begin
                if (reset_in)
                begin
                    ram_head_valid <= 1'b0;
                end
                else
                begin
                    ram_head_valid <= entry_valid[read_ptr] & ~pop;
                end
            end

            assign head_data = entry_t'(ram_read_data);
            assign head_ready = ram_head_valid;

            dual_port_blockram
            #(
                .entry_width ($bits(entry_t)),
                .num_entries (depth)
            )
            storage_ram
            (
                .clk_in (clk_in),
                .reset_in (reset_in),
                .port_a_write_mask (ram_write_mask),
                .port_a_addr (write_ptr),
                .port_a_write_data (request_in),
                .port_b_addr (read_ptr),
                .port_b_read_data (ram_read_data)
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: verilog/request_arbiter.sv
`default_nettype none

module request_arbiter
(
    input logic clk_in,
    input logic reset_in,

    input mem_pkg::mem_request_t req_a,
    input logic req_a_valid,
    output logic req_a_ack,

    input mem_pkg::mem_request_t req_b,
    input logic req_b_valid,
    output logic req_b_ack,

    output mem_pkg::mem_request_t queue_req,
    output logic queue_valid,
    input logic queue_ack
);

    import mem_pkg::*;

    client_id_t last_served;
    client_id_t grant;
    logic locked;
    client_id_t sel;

    // While an offer is outstanding the grant stays put
    always_comb
    begin
        if (locked)
        begin
            sel = grant;
        end
        else if (req_a_valid && req_b_valid)
        begin
            sel = ~last_served;
        end
        else if (req_b_valid)
        begin
            sel = client_b;
        end
        else
        begin
            sel = client_a;
        end
    end

    always_comb
    begin
        queue_valid = (sel == client_b) ? req_b_valid : req_a_valid;
        queue_req = (sel == client_b) ? req_b : req_a;
        queue_req.client = sel;
    end

    assign req_a_ack = queue_ack & (sel == client_a);
    assign req_b_ack = queue_ack & (sel == client_b);

    // Starting with B as last served lets A win the first tie
    always_ff @(posedge clk_in, posedge reset_in)
    begin
        if (reset_in)
        begin
            locked <= 1'b0;
            grant <= client_a;
            last_served <= client_b;
        end
        else if (queue_ack)
        begin
            locked <= 1'b0;
            last_served <= grant;
        end
        else if (queue_valid && !locked)
        begin
            locked <= 1'b1;
            grant <= sel;
        end
    end

endmodule

`default_nettype wire

// File: verilog/memory_backend.sv
`default_nettype none

module memory_backend
(
    input logic clk_in,
    input logic reset_in,

    input mem_pkg::mem_request_t pop_req,
    input logic pop_valid,
    output logic pop_ack,

    output mem_pkg::mem_response_t push_resp,
    output logic push_valid,
    input logic push_ack
);

    import mem_pkg::*;

    backend_state_t state;
    mem_request_t req_q;

    logic accept;
    logic [mask_width - 1 : 0] ram_write_mask;
    logic [addr_width - 1 : 0] ram_read_addr;
    logic [data_width - 1 : 0] ram_read_data;

    assign accept = (state == st_idle) & pop_valid;
    assign pop_ack = accept;

    // The write lands on the same edge the request is popped
    assign ram_write_mask = (accept && pop_req.opcode == op_write) ? pop_req.write_mask : '0;

    // Keep reading the latched address so the word stays put until the response leaves
    assign ram_read_addr = (state == st_idle) ? pop_req.addr : req_q.addr;

    always_ff @(posedge clk_in, posedge reset_in)
    begin
        if (reset_in)
        begin
            state <= st_idle;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (pop_valid)
                    begin
                        state <= st_access;
                    end
                end
                st_access:
                begin
                    state <= st_respond;
                end
                st_respond:
                begin
                    if (push_ack)
                    begin
                        state <= st_idle;
                    end
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
        begin
            req_q <= pop_req;
        end
    end

    assign push_valid = (state == st_respond);

    always_comb
    begin
        push_resp.client = req_q.client;
        push_resp.opcode = req_q.opcode;
        push_resp.read_data = (req_q.opcode == op_read) ? ram_read_data : '0;
    end

    dual_port_blockram
    #(
        .entry_width (data_width),
        .num_entries (mem_depth)
    )
    main_memory
    (
        .clk_in (clk_in),
        .reset_in (reset_in),
        .port_a_write_mask (ram_write_mask),
        .port_a_addr (pop_req.addr),
        .port_a_write_data (pop_req.write_data),
        .port_b_addr (ram_read_addr),
        .port_b_read_data (ram_read_data)
    );

endmodule

`default_nettype wire

// File: verilog/mem_subsystem_top.sv
`default_nettype none

module mem_subsystem_top
(
    input logic clk_in,
    input logic reset_in,

    input mem_pkg::mem_request_t req_a,
    input logic req_a_valid,
    output logic req_a_ack,

    input mem_pkg::mem_request_t req_b,
    input logic req_b_valid,
    output logic req_b_ack,

    output mem_pkg::mem_response_t response,
    output logic response_valid,
    input logic response_ack
);

    import mem_pkg::*;

    mem_request_t queue_req;
    logic queue_valid;
    logic queue_ack;

    mem_request_t pop_req;
    logic pop_valid;
    logic pop_ack;

    mem_response_t push_resp;
    logic push_valid;
    logic push_ack;

    request_arbiter request_arbiter_inst
    (
        .clk_in (clk_in),
        .reset_in (reset_in),
        .req_a (req_a),
        .req_a_valid (req_a_valid),
        .req_a_ack (req_a_ack),
        .req_b (req_b),
        .req_b_valid (req_b_valid),
        .req_b_ack (req_b_ack),
        .queue_req (queue_req),
        .queue_valid (queue_valid),
        .queue_ack (queue_ack)
    );

    fifo_queue
    #(
        .entry_t (mem_request_t),
        .depth (queue_depth),
        .storage_type ("BlockRAM")
    )
    req_queue
    (
        .clk_in (clk_in),
        .reset_in (reset_in),
        .is_empty (),
        .is_full (),
        .request_in (queue_req),
        .request_valid_in (queue_valid),
        .issue_ack_out (queue_ack),
        .request_out (pop_req),
        .request_valid_out (pop_valid),
        .issue_ack_in (pop_ack)
    );

    memory_backend memory_backend_inst
    (
        .clk_in (clk_in),
        .reset_in (reset_in),
        .pop_req (pop_req),
        .pop_valid (pop_valid),
        .pop_ack (pop_ack),
        .push_resp (push_resp),
        .push_valid (push_valid),
        .push_ack (push_ack)
    );

    fifo_queue
    #(
        .entry_t (mem_response_t),
        .depth (queue_depth),
        .storage_type ("FlipFlop")
    )
    resp_queue
    (
        .clk_in (clk_in),
        .reset_in (reset_in),
        .is_empty (),
        .is_full (),
        .request_in (push_resp),
        .request_valid_in (push_valid),
        .issue_ack_out (push_ack),
        .request_out (response),
        .request_valid_out (response_valid),
        .issue_ack_in (response_ack)
    );

endmodule

`default_nettype wire

// File: bench/mem_subsystem_assertions.sv
`default_nettype none

module mem_subsystem_assertions
(
    input logic clk_in,
    input logic reset_in,
    input logic is_empty,
    input logic issue_ack_out,
    input logic request_valid_out,
    input logic issue_ack_in
);

    timeunit 1ns;
    timeprecision 1ps;

    int failure_count = 0;

    // The write-side ack is a one-cycle pulse
    ack_single_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
        issue_ack_out |=> !issue_ack_out)
    else
    begin
        $error("issue_ack_out stayed high for two cycles");
        failure_count++;
    end

    valid_rise_not_empty: assert property (@(posedge clk_in) disable iff (reset_in)
        $rose(request_valid_out) |-> !is_empty)
    else
    begin
        $error("request_valid_out rose while the queue was empty");
        failure_count++;
    end

    pop_not_empty: assert property (@(posedge clk_in) disable iff (reset_in)
        (issue_ack_in && request_valid_out) |-> !is_empty)
    else
    begin
        $error("Entry popped while the queue was empty");
        failure_count++;
    end

endmodule

bind fifo_queue mem_subsystem_assertions fifo_checks
(
    .clk_in (clk_in),
    .reset_in (reset_in),
    .is_empty (is_empty),
    .issue_ack_out (issue_ack_out),
    .request_valid_out (request_valid_out),
    .issue_ack_in (issue_ack_in)
);

`default_nettype wire

// File: bench/mem_subsystem_tb.sv
`default_nettype none

module mem_subsystem_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    localparam int clk_period = 20;
    localparam int reset_cycles = 5;
    // Preload 64, then 2, 2, 16, 16 and 30 requests
    localparam int total_transactions = 130;
    localparam int watchdog_cycles = total_transactions * 40;

    logic clk_in = 1'b0;
    logic reset_in;
    mem_request_t req_a;
    logic req_a_valid;
    logic req_a_ack;
    mem_request_t req_b;
    logic req_b_valid;
    logic req_b_ack;
    mem_response_t response;
    logic response_valid;
    logic response_ack;

    logic resp_enable = 1'b1;

    logic [data_width - 1 : 0] ref_mem [mem_depth];
    mem_request_t pend_a [$];
    mem_request_t pend_b [$];
    mem_response_t exp_a [$];
    mem_response_t exp_b [$];
    client_id_t ack_log [$];

    string current_test;
    int ack_count;
    int test_count = 0;
    int check_count = 0;
    int error_count = 0;
    int test_start_errors;
    int assertion_failures;

    mem_subsystem_top mem_subsystem_top_inst
    (
        .clk_in (clk_in),
        .reset_in (reset_in),
        .req_a (req_a),
        .req_a_valid (req_a_valid),
        .req_a_ack (req_a_ack),
        .req_b (req_b),
        .req_b_valid (req_b_valid),
        .req_b_ack (req_b_ack),
        .response (response),
        .response_valid (response_valid),
        .response_ack (response_ack)
    );

    always #(clk_period / 2) clk_in = ~clk_in;

    function automatic mem_request_t make_request(
        input mem_opcode_t op,
        input logic [addr_width - 1 : 0] addr,
        input logic [mask_width - 1 : 0] mask,
        input logic [data_width - 1 : 0] data
    );
        mem_request_t req;
        req.client = client_a;
        req.opcode = op;
        req.addr = addr;
        req.write_mask = mask;
        req.write_data = data;
        return req;
    endfunction

    // Every byte carries the full address, so no two words match
    function automatic logic [data_width - 1 : 0] fill_word(input logic [addr_width - 1 : 0] addr);
        return {mask_width{addr, 2'b10}};
    endfunction

    // Reference memory: a write replaces only the bytes whose mask bit is set
    function automatic mem_response_t model_access(input client_id_t which,
                                                   input mem_request_t req);
        mem_response_t resp;
        resp.client = which;
        resp.opcode = req.opcode;
        resp.read_data = '0;
        if (req.opcode == op_write)
        begin
            for (int b = 0; b < mask_width; b++)
            begin
                if (req.write_mask[b])
                begin
                    ref_mem[req.addr][b * byte_len +: byte_len] =
                        req.write_data[b * byte_len +: byte_len];
                end
            end
        end
        else
        begin
            resp.read_data = ref_mem[req.addr];
        end
        return resp;
    endfunction

    task automatic begin_test(input string name);
        current_test = name;
        test_start_errors = error_count;
        ack_log.delete();
        ack_count = 0;
    endtask

    task automatic end_test();
        test_count++;
        $display("%s: %s, %0d errors", current_test,
                 (error_count == test_start_errors) ? "ok" : "failed",
                 error_count - test_start_errors);
    endtask

    task automatic drive_port(input client_id_t which, input mem_request_t req,
                              input logic valid);
        if (which == client_a)
        begin
            req_a = req;
            req_a_valid = valid;
        end
        else
        begin
            req_b = req;
            req_b_valid = valid;
        end
    endtask

    task automatic record_accept(input client_id_t which, input mem_request_t req);
        mem_response_t resp;
        resp = model_access(which, req);
        if (which == client_a)
        begin
            exp_a.push_back(resp);
        end
        else
        begin
            exp_b.push_back(resp);
        end
        ack_log.push_back(which);
        ack_count++;
    endtask

    // Offers a client's pending requests one by one, holding each until its ack pulse
    task automatic feed_client(input client_id_t which);
        mem_request_t req;
        logic acked;
        while ((which == client_a) ? (pend_a.size() != 0) : (pend_b.size() != 0))
        begin
            if (which == client_a)
            begin
                req = pend_a.pop_front();
            end
            else
            begin
                req = pend_b.pop_front();
            end
            // The field names the other port, so only the arbiter's stamp tags the response
            req.client = ~which;
            drive_port(which, req, 1'b1);
            acked = 1'b0;
            while (!acked)
            begin
                @(negedge clk_in);
                acked = (which == client_a) ? req_a_ack : req_b_ack;
            end
            record_accept(which, req);
            @(posedge clk_in);
            #1;
        end
        drive_port(which, '0, 1'b0);
    endtask

    task automatic check_response(input mem_response_t actual);
        mem_response_t expected;
        logic outstanding;
        outstanding = (actual.client == client_a) ? (exp_a.size() != 0) : (exp_b.size() != 0);
        check_count++;
        assert (outstanding)
        else
        begin
            $display("Response for client %0d arrived with no request outstanding in %s",
                     actual.client, current_test);
            error_count++;
        end
        if (outstanding)
        begin
            if (actual.client == client_a)
            begin
                expected = exp_a.pop_front();
            end
            else
            begin
                expected = exp_b.pop_front();
            end
            assert (actual == expected)
            else
            begin
                $display("Error: %s expected %h actual %h", current_test, expected, actual);
                error_count++;
            end
        end
    endtask

    task automatic wait_drained();
        while (exp_a.size() != 0 || exp_b.size() != 0)
        begin
            @(posedge clk_in);
        end
        @(posedge clk_in);
        #1;
    endtask

    task automatic run_both_clients();
        fork
            feed_client(client_a);
            feed_client(client_b);
        join
        wait_drained();
    endtask

    task automatic idle_after_reset();
        begin_test("idle_after_reset");
        repeat (10)
        begin
            @(negedge clk_in);
            check_count++;
            assert (!req_a_ack && !req_b_ack && !response_valid)
            else
            begin
                $display("An ack or response_valid went high with no request driven");
                error_count++;
            end
        end
        @(posedge clk_in);
        #1;
        end_test();
    endtask

    task automatic preload_memory();
        begin_test("preload_memory");
        for (int i = 0; i < mem_depth; i++)
        begin
            if (i % 2 == 0)
            begin
                pend_a.push_back(make_request(op_write, addr_width'(i), '1,
                                              fill_word(addr_width'(i))));
            end
            else
            begin
                pend_b.push_back(make_request(op_write, addr_width'(i), '1,
                                              fill_word(addr_width'(i))));
            end
        end
        run_both_clients();
        end_test();
    endtask

    task automatic write_then_read();
        begin_test("write_then_read");
        pend_a.push_back(make_request(op_write, 6'd5, 8'hff, 64'hdead_beef_0123_4567));
        pend_a.push_back(make_request(op_read, 6'd5, 8'h00, 64'h0));
        run_both_clients();
        end_test();
    endtask

    task automatic partial_mask_write();
        begin_test("partial_mask");
        pend_b.push_back(make_request(op_write, 6'd9, 8'b1010_0101, 64'hffee_ddcc_bbaa_9988));
        pend_b.push_back(make_request(op_read, 6'd9, 8'h00, 64'h0));
        run_both_clients();
        end_test();
    endtask

    task automatic round_robin_order();
        begin_test("round_robin");
        for (int i = 0; i < 8; i++)
        begin
            pend_a.push_back(make_request(op_write, addr_width'(16 + i), 8'hff,
                                          {32'ha5a5_0000 + i, 32'h1}));
            pend_b.push_back(make_request(op_read, addr_width'(16 + i), 8'h00, 64'h0));
        end
        run_both_clients();
        for (int i = 1; i < ack_log.size(); i++)
        begin
            check_count++;
            assert (ack_log[i] != ack_log[i - 1])
            else
            begin
                $display("Client %0d was acknowledged twice in a row in %s",
                         ack_log[i], current_test);
                error_count++;
            end
        end
        end_test();
    endtask

    task automatic response_backpressure();
        int idle_cycles;
        int last_count;
        begin_test("backpressure");
        resp_enable = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            pend_a.push_back(make_request(op_read, addr_width'(i), 8'h00, 64'h0));
            pend_b.push_back(make_request(op_write, addr_width'(32 + i), 8'h0f,
                                          {2{32'h5a5a_0000 + i}}));
        end
        fork
            feed_client(client_a);
            feed_client(client_b);
            begin
                idle_cycles = 0;
                last_count = 0;
                while (idle_cycles < 20)
                begin
                    @(negedge clk_in);
                    if (ack_count != last_count)
                    begin
                        last_count = ack_count;
                        idle_cycles = 0;
                    end
                    else
                    begin
                        idle_cycles++;
                    end
                end
                // Both queues full plus the one request held by the backend
                check_count++;
                assert (ack_count == 2 * queue_depth + 1)
                else
                begin
                    $display("Error: %s expected %0d accepted requests actual %0d",
                             current_test, 2 * queue_depth + 1, ack_count);
                    error_count++;
                end
                resp_enable = 1'b1;
            end
        join
        wait_drained();
        end_test();
    endtask

    task automatic random_traffic();
        mem_request_t req;
        begin_test("random_traffic");
        for (int i = 0; i < 30; i++)
        begin
            req = make_request(($urandom_range(0, 1) == 0) ? op_read : op_write,
                               addr_width'($urandom_range(0, mem_depth - 1)),
                               mask_width'($urandom), {$urandom, $urandom});
            if (i % 2 == 0)
            begin
                pend_a.push_back(req);
            end
            else
            begin
                pend_b.push_back(req);
            end
        end
        run_both_clients();
        end_test();
    endtask

    // Response consumer: acks whatever is valid while enabled
    initial
    begin
        response_ack = 1'b0;
        forever
        begin
            @(posedge clk_in);
            #1;
            response_ack = 1'b0;
            if (resp_enable && response_valid && !reset_in)
            begin
                check_response(response);
                response_ack = 1'b1;
            end
        end
    end

    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h071a4dd7));
        reset_in = 1'b1;
        req_a = '0;
        req_a_valid = 1'b0;
        req_b = '0;
        req_b_valid = 1'b0;
        repeat (reset_cycles) @(posedge clk_in);
        #1;
        reset_in = 1'b0;

        idle_after_reset();
        preload_memory();
        write_then_read();
        partial_mask_write();
        round_robin_order();
        response_backpressure();
        random_traffic();

        assertion_failures = mem_subsystem_top_inst.req_queue.fifo_checks.failure_count
                           + mem_subsystem_top_inst.resp_queue.fifo_checks.failure_count;
        check_count++;
        assert (assertion_failures == 0)
        else
        begin
            $display("Queue handshake assertions failed %0d times", assertion_failures);
            error_count++;
        end

        $display("Tests run: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/mem_pkg.sv
verilog/dual_port_blockram.sv
verilog/fifo_queue.sv
verilog/request_arbiter.sv
verilog/memory_backend.sv
verilog/mem_subsystem_top.sv
bench/mem_subsystem_assertions.sv
bench/mem_subsystem_tb.sv

// File: Makefile
TOP := mem_subsystem_tb
SIM := obj_dir/V$(TOP)

.PHONY: run clean

run: $(SIM)
	$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

$(SIM): sim.f $(wildcard verilog/*.sv bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log
